// File: src/lu_macros.svh
`ifndef LU_MACROS_SVH
`define LU_MACROS_SVH

// matrix dimension
`define LU_SIZE 4

// q7.8 fraction bits
`define LU_FRAC 8

// row address width
`define LU_AW 2

`endif

// File: src/lu_pkg.sv
`include "lu_macros.svh"

package lu_pkg;

  // one complex q7.8 value
  typedef struct packed {
    logic signed [15:0] re;
    logic signed [15:0] im;
  } cplx_t;

  typedef cplx_t [`LU_SIZE-1:0] row_t;

  // one pivot step as seen on the result port
  typedef struct packed {
    logic [`LU_AW-1:0] addr;   // pivot index k
    row_t              l_col;
    row_t              u_row;
  } result_t;

endpackage

// File: src/complex_mul.sv
`timescale 1ns/1ps
`include "lu_macros.svh"

module complex_mul (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          valid_i,
  input  lu_pkg::cplx_t a_i,
  input  lu_pkg::cplx_t b_i,
  output logic          valid_o,
  output lu_pkg::cplx_t p_o
);

  logic signed [31:0] rr, ii, ri, ir;   // partial products
  logic signed [31:0] re_full, im_full;
  logic               vld_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      vld_q   <= 1'b0;
      valid_o <= 1'b0;
    end else begin
      vld_q   <= valid_i;
      valid_o <= vld_q;
    end
  end

  assign re_full = rr - ii;
  assign im_full = ri + ir;

  always_ff @(posedge clk_i) begin
    rr     <= a_i.re * b_i.re;
    ii     <= a_i.im * b_i.im;
    ri     <= a_i.re * b_i.im;
    ir     <= a_i.im * b_i.re;
    p_o.re <= 16'(re_full >>> `LU_FRAC);   // drop fraction, truncate
    p_o.im <= 16'(im_full >>> `LU_FRAC);
  end

endmodule

// File: src/complex_recip.sv
`timescale 1ns/1ps

module complex_recip (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          start_i,
  input  lu_pkg::cplx_t z_i,
  output logic          valid_o,
  output lu_pkg::cplx_t r_o
);

  logic [15:0] mag_re, mag_im;
  logic [31:0] den;
  logic [31:0] rem_re, rem_im;
  logic [31:0] dvd_re, dvd_im;   // dividend in, quotient out
  logic        neg_re, neg_im;
  logic        run, fin;
  logic [4:0]  cnt;

  // one restoring step, quotient bit shifts in at the bottom
  function automatic logic [63:0] div_step(input logic [31:0] rem,
                                           input logic [31:0] dvd,
                                           input logic [31:0] d);
    logic [32:0] trial;
    trial = {rem, dvd[31]};
    if (trial >= {1'b0, d}) begin
      return {32'(trial - {1'b0, d}), dvd[30:0], 1'b1};
    end
    return {trial[31:0], dvd[30:0], 1'b0};
  endfunction

  function automatic logic signed [15:0] sat(input logic neg, input logic [31:0] q);
    if (!neg) begin
      return (q > 32'd32767) ? 16'sh7fff : q[15:0];
    end
    return (q > 32'd32768) ? 16'sh8000 : 16'(-q);
  endfunction

  // -32768 wraps to 0x8000, still right as unsigned
  assign mag_re = z_i.re[15] ? 16'(-z_i.re) : z_i.re;
  assign mag_im = z_i.im[15] ? 16'(-z_i.im) : z_i.im;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      run     <= 1'b0;
      fin     <= 1'b0;
      cnt     <= '0;
      valid_o <= 1'b0;
    end else begin
      valid_o <= fin;
      fin     <= 1'b0;
      if (start_i) begin
        run <= 1'b1;
        cnt <= '0;
      end else if (run) begin
        cnt <= cnt + 5'd1;
        if (cnt == 5'd31) begin   // last of 32 steps
          run <= 1'b0;
          fin <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      den    <= mag_re * mag_re + mag_im * mag_im;
      dvd_re <= {mag_re, 16'h0000};   // |c| * 65536
      dvd_im <= {mag_im, 16'h0000};
      rem_re <= '0;
      rem_im <= '0;
      neg_re <= z_i.re[15];
      neg_im <= ~z_i.im[15];          // imag part is -d / den
    end else if (run) begin
      {rem_re, dvd_re} <= div_step(rem_re, dvd_re, den);
      {rem_im, dvd_im} <= div_step(rem_im, dvd_im, den);
    end
    if (fin) begin
      r_o.re <= sat(neg_re, dvd_re);
      r_o.im <= sat(neg_im, dvd_im);
    end
  end

endmodule

// File: src/lu_row_bank.sv
`timescale 1ns/1ps
`include "lu_macros.svh"

module lu_row_bank (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              load_en_i,
  input  logic [`LU_AW-1:0] load_addr_i,
  input  lu_pkg::row_t      load_row_i,
  input  logic [`LU_AW-1:0] rd_a_addr_i,
  output lu_pkg::row_t      rd_a_row_o,
  input  logic [`LU_AW-1:0] rd_b_addr_i,
  output lu_pkg::row_t      rd_b_row_o,
  input  logic              wr_en_i,
  input  logic [`LU_AW-1:0] wr_addr_i,
  input  lu_pkg::row_t      wr_row_i
);

  lu_pkg::row_t rows [`LU_SIZE];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int r = 0; r < `LU_SIZE; r++) begin
        rows[r] <= '0;
      end
    end else if (wr_en_i) begin   // engine write wins
      rows[wr_addr_i] <= wr_row_i;
    end else if (load_en_i) begin
      rows[load_addr_i] <= load_row_i;
    end
  end

  // engine port a, host port b
  always_ff @(posedge clk_i) begin
    rd_a_row_o <= rows[rd_a_addr_i];
    rd_b_row_o <= rows[rd_b_addr_i];
  end

endmodule

// File: src/lu_engine.sv
`timescale 1ns/1ps
`include "lu_macros.svh"

module lu_engine (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              start_i,
  output logic              busy_o,
  output logic [`LU_AW-1:0] rd_addr_o,
  input  lu_pkg::row_t      rd_row_i,
  output logic              wr_en_o,
  output logic [`LU_AW-1:0] wr_addr_o,
  output lu_pkg::row_t      wr_row_o,
  output logic              recip_start_o,
  output lu_pkg::cplx_t     recip_z_o,
  input  logic              recip_valid_i,
  input  lu_pkg::cplx_t     recip_r_i,
  output logic              fmul_valid_o,
  output lu_pkg::cplx_t     fmul_a_o,
  output lu_pkg::cplx_t     fmul_b_o,
  input  logic              fmul_valid_i,
  input  lu_pkg::cplx_t     fmul_p_i,
  output logic              vmul_valid_o,
  output lu_pkg::row_t      vmul_a_o,
  output lu_pkg::row_t      vmul_b_o,
  input  logic              vmul_valid_i,
  input  lu_pkg::row_t      vmul_p_i,
  output lu_pkg::result_t   result_o,
  output logic              result_valid_o,
  input  logic              result_ready_i
);

  typedef enum logic [2:0] {
    IDLE, PIVOT_RD, RECIP, ROW_RD, FACTOR, UPDATE, WRITE, EMIT
  } state_t;

  localparam logic [`LU_AW-1:0] LAST = `LU_AW'(`LU_SIZE - 1);
  localparam lu_pkg::cplx_t     ONE  = '{re: 16'(1 << `LU_FRAC), im: 16'sd0};

  state_t            state;
  logic              go;      // first cycle of RECIP, FACTOR or UPDATE
  logic [`LU_AW-1:0] k, i;
  lu_pkg::row_t      u_row, l_col, wr_row;
  lu_pkg::cplx_t     recip;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state <= IDLE;
      go    <= 1'b0;
      k     <= '0;
      i     <= '0;
    end else begin
      go <= 1'b0;
      case (state)
        IDLE: begin
          if (start_i) begin
            k     <= '0;
            state <= PIVOT_RD;
          end
        end
        PIVOT_RD: begin
          state <= RECIP;
          go    <= 1'b1;
        end
        RECIP: begin
          if (recip_valid_i) begin
            i     <= k + 1'b1;
            state <= ROW_RD;
          end
        end
        ROW_RD: begin
          state <= FACTOR;
          go    <= 1'b1;
        end
        FACTOR: begin
          if (fmul_valid_i) begin
            state <= UPDATE;
            go    <= 1'b1;
          end
        end
        UPDATE: begin
          if (vmul_valid_i) state <= WRITE;
        end
        WRITE: begin
          if (i == LAST) begin
            state <= EMIT;
          end else begin
            i     <= i + 1'b1;
            state <= ROW_RD;
          end
        end
        EMIT: begin
          if (result_ready_i) begin
            if (k == LAST - 1'b1) begin   // last pivot done
              state <= IDLE;
            end else begin
              k     <= k + 1'b1;
              state <= PIVOT_RD;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state == RECIP && go) begin
      for (int j = 0; j < `LU_SIZE; j++) begin
        u_row[j] <= (`LU_AW'(j) < k) ? '0 : rd_row_i[j];
        l_col[j] <= (`LU_AW'(j) == k) ? ONE : '0;
      end
    end
    if (state == RECIP && recip_valid_i) recip <= recip_r_i;
    if (state == FACTOR && fmul_valid_i) l_col[i] <= fmul_p_i;
    if (state == UPDATE && vmul_valid_i) begin
      for (int j = 0; j < `LU_SIZE; j++) begin
        wr_row[j].re <= rd_row_i[j].re - vmul_p_i[j].re;   // wraps
        wr_row[j].im <= rd_row_i[j].im - vmul_p_i[j].im;
      end
    end
  end

  // row i stays on the read port from ROW_RD until its write
  assign rd_addr_o = (state inside {ROW_RD, FACTOR, UPDATE, WRITE}) ? i : k;

  assign recip_start_o = go && (state == RECIP);
  assign recip_z_o     = rd_row_i[k];

  assign fmul_valid_o = go && (state == FACTOR);
  assign fmul_a_o     = rd_row_i[k];
  assign fmul_b_o     = recip;

  assign vmul_valid_o = go && (state == UPDATE);
  assign vmul_b_o     = u_row;

  always_comb begin
    for (int j = 0; j < `LU_SIZE; j++) begin
      vmul_a_o[j] = l_col[i];   // l_ik to every lane
    end
  end

  assign wr_en_o   = (state == WRITE);
  assign wr_addr_o = i;
  assign wr_row_o  = wr_row;

  assign busy_o         = (state != IDLE);
  assign result_valid_o = (state == EMIT);
  assign result_o       = '{addr: k, l_col: l_col, u_row: u_row};

endmodule

// File: src/lu_top.sv
`timescale 1ns/1ps
`include "lu_macros.svh"

module lu_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              load_en_i,
  input  logic [`LU_AW-1:0] load_addr_i,
  input  lu_pkg::row_t      load_row_i,
  input  logic              start_i,
  output lu_pkg::result_t   result_o,
  output logic              result_valid_o,
  input  logic              result_ready_i,
  input  logic [`LU_AW-1:0] rd_addr_i,
  output lu_pkg::row_t      rd_row_o,
  output logic              busy_o
);

  logic [`LU_AW-1:0]  eng_rd_addr, eng_wr_addr;
  lu_pkg::row_t       eng_rd_row, eng_wr_row;
  logic               eng_wr_en;
  lu_pkg::cplx_t      recip_in, recip_out;
  logic               recip_start, recip_valid;
  lu_pkg::cplx_t      fmul_a, fmul_b, fmul_p;
  logic               fmul_valid_in, fmul_valid_out;
  lu_pkg::row_t       vmul_a, vmul_b, vmul_p;
  logic               vmul_valid_in;
  logic [`LU_SIZE-1:0] row_valid;

  lu_row_bank bank (
    .clk_i, .rst_ni,
    .load_en_i   (load_en_i & ~busy_o),   // no loads during a run
    .load_addr_i, .load_row_i,
    .rd_a_addr_i (eng_rd_addr), .rd_a_row_o (eng_rd_row),
    .rd_b_addr_i (rd_addr_i),   .rd_b_row_o (rd_row_o),
    .wr_en_i     (eng_wr_en), .wr_addr_i (eng_wr_addr), .wr_row_i (eng_wr_row)
  );

  lu_engine engine (
    .clk_i, .rst_ni, .start_i, .busy_o,
    .rd_addr_o     (eng_rd_addr), .rd_row_i (eng_rd_row),
    .wr_en_o       (eng_wr_en), .wr_addr_o (eng_wr_addr), .wr_row_o (eng_wr_row),
    .recip_start_o (recip_start), .recip_z_o (recip_in),
    .recip_valid_i (recip_valid), .recip_r_i (recip_out),
    .fmul_valid_o  (fmul_valid_in), .fmul_a_o (fmul_a), .fmul_b_o (fmul_b),
    .fmul_valid_i  (fmul_valid_out), .fmul_p_i (fmul_p),
    .vmul_valid_o  (vmul_valid_in), .vmul_a_o (vmul_a), .vmul_b_o (vmul_b),
    .vmul_valid_i  (&row_valid), .vmul_p_i (vmul_p),
    .result_o, .result_valid_o, .result_ready_i
  );

  complex_recip recip (
    .clk_i, .rst_ni, .start_i (recip_start), .z_i (recip_in),
    .valid_o (recip_valid), .r_o (recip_out)
  );

  complex_mul factor_mul (
    .clk_i, .rst_ni, .valid_i (fmul_valid_in), .a_i (fmul_a), .b_i (fmul_b),
    .valid_o (fmul_valid_out), .p_o (fmul_p)
  );

  for (genvar j = 0; j < `LU_SIZE; j++) begin : g_row
    complex_mul row_mul (
      .clk_i, .rst_ni, .valid_i (vmul_valid_in), .a_i (vmul_a[j]), .b_i (vmul_b[j]),
      .valid_o (row_valid[j]), .p_o (vmul_p[j])
    );
  end

endmodule

// File: sim/lu_props.sv
`timescale 1ns/1ps
`include "lu_macros.svh"

module lu_props (
  input logic            clk_i,
  input logic            rst_ni,
  input logic            busy_o,
  input lu_pkg::result_t result_o,
  input logic            result_valid_o,
  input logic            result_ready_i,
  input logic            recip_start,
  input logic            recip_valid
);

  logic              taken;
  logic [`LU_AW-1:0] next_addr;   // pivot index expected next

  assign taken = result_valid_o && result_ready_i;

  // each run restarts at pivot 0
  always_ff @(posedge clk_i) begin
    if (!rst_ni || !busy_o) begin
      next_addr <= '0;
    end else if (taken) begin
      next_addr <= result_o.addr + `LU_AW'(1);
    end
  end

  hold_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_valid_o && !result_ready_i |=> result_valid_o && $stable(result_o))
    else $error("result changed or dropped while stalled");

  idle_after_reset: assert property (@(posedge clk_i)
    !rst_ni |=> !busy_o && !result_valid_o)
    else $error("busy or valid high after reset");

  addr_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    taken |-> result_o.addr == next_addr)
    else $error("result address out of order");

  recip_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    recip_valid == $past(recip_start, 34))
    else $error("reciprocal valid not 34 cycles after start");

endmodule

bind lu_top lu_props props (
  .clk_i, .rst_ni, .busy_o, .result_o, .result_valid_o, .result_ready_i,
  .recip_start, .recip_valid
);

// File: sim/lu_tb.sv
`timescale 1ns/1ps
`include "lu_macros.svh"

module lu_tb;

  localparam int N      = `LU_SIZE;
  localparam int NCASES = 5;
  localparam int CYCLES = NCASES * (N * 400 + 200);   // watchdog budget

  logic              clk_i;
  logic              rst_ni;
  logic              load_en_i, start_i, result_ready_i;
  logic              result_valid_o, busy_o;
  logic [`LU_AW-1:0] load_addr_i, rd_addr_i;
  lu_pkg::row_t      load_row_i, rd_row_o;
  lu_pkg::result_t   result_o;

  // stimulus table
  string        case_name  [NCASES];
  lu_pkg::row_t case_mat   [NCASES][N];
  int           case_stall [NCASES];   // ready low cycles per result
  bit           case_poke  [NCASES];   // loads and start while busy

  lu_pkg::result_t exp_res  [N-1];
  lu_pkg::row_t    exp_rows [N];
  logic [31:0]     rng;
  int              val_errs;
  int              proto_errs;

  lu_top UUT (.*);

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic lu_pkg::cplx_t mul_q(input lu_pkg::cplx_t a, input lu_pkg::cplx_t b);
    int            re;
    int            im;
    lu_pkg::cplx_t p;
    re   = int'(a.re) * int'(b.re) - int'(a.im) * int'(b.im);
    im   = int'(a.re) * int'(b.im) + int'(a.im) * int'(b.re);
    p.re = 16'(re >>> `LU_FRAC);
    p.im = 16'(im >>> `LU_FRAC);
    return p;
  endfunction

  function automatic logic signed [15:0] clip(input longint v);
    if (v > 32767) return 16'sh7fff;
    if (v < -32768) return 16'sh8000;
    return 16'(v);
  endfunction

  // 1/(c+di) = (c - di) / (c^2 + d^2), division truncates toward zero
  function automatic lu_pkg::cplx_t recip_q(input lu_pkg::cplx_t z);
    longint        c;
    longint        d;
    longint        den;
    lu_pkg::cplx_t r;
    c    = z.re;
    d    = z.im;
    den  = c * c + d * d;
    r.re = clip(c * 65536 / den);
    r.im = clip(-d * 65536 / den);
    return r;
  endfunction

  function automatic lu_pkg::cplx_t rand_elem(input bit diag);
    lu_pkg::cplx_t e;
    rng = xorshift(rng);
    if (diag) begin   // large diagonal keeps pivots away from zero
      e.re = 16'(1024 + int'(rng[7:0]));
      e.im = 16'(int'(rng[15:8]) - 128);
    end else begin
      e.re = 16'(int'(rng[7:0]) - 128);
      e.im = 16'(int'(rng[23:16]) - 128);
    end
    return e;
  endfunction

  task automatic build_table();
    lu_pkg::cplx_t e;
    case_name[0] = "identity";
    case_name[1] = "fixed_real";
    case_name[2] = "random_a";
    case_name[3] = "random_stall";
    case_name[4] = "random_busy_poke";
    for (int c = 0; c < NCASES; c++) begin
      case_stall[c] = (c == 3) ? 6 : (c == 4) ? 2 : (c == 1) ? 1 : 0;
      case_poke[c]  = (c == 4);
      for (int i = 0; i < N; i++) begin
        for (int j = 0; j < N; j++) begin
          e = '0;
          if (c == 0) begin
            e.re = (i == j) ? 16'(1 << `LU_FRAC) : 16'sd0;
          end else if (c == 1) begin
            e.re = 16'((i == j) ? 1024 + 64 * i : 32 * (i + 2 * j + 1) - 96);
          end else begin
            e = rand_elem(i == j);
          end
          case_mat[c][i][j] = e;
        end
      end
    end
  endtask

  // doolittle without pivoting, same integer rules as the hardware
  task automatic model_lu(input int c);
    lu_pkg::row_t  a [N];
    lu_pkg::row_t  u;
    lu_pkg::row_t  l;
    lu_pkg::cplx_t r, f, p;
    for (int i = 0; i < N; i++) a[i] = case_mat[c][i];
    for (int k = 0; k < N - 1; k++) begin
      r = recip_q(a[k][k]);
      u = a[k];
      l = '0;
      for (int j = 0; j < k; j++) u[j] = '0;
      l[k].re = 16'(1 << `LU_FRAC);
      for (int i = k + 1; i < N; i++) begin
        f    = mul_q(a[i][k], r);
        l[i] = f;
        for (int j = 0; j < N; j++) begin
          p          = mul_q(f, u[j]);
          a[i][j].re = a[i][j].re - p.re;
          a[i][j].im = a[i][j].im - p.im;
        end
      end
      exp_res[k] = '{addr: `LU_AW'(k), l_col: l, u_row: u};
    end
    for (int i = 0; i < N; i++) exp_rows[i] = a[i];
  endtask

  task automatic check_result(input string name, input lu_pkg::result_t exp,
                              input lu_pkg::result_t act);
    if (act !== exp) begin
      $display("FAIL %s result: expected %h got %h", name, exp, act);
      val_errs++;
    end
  endtask

  task automatic check_row(input string name, input lu_pkg::row_t exp, input lu_pkg::row_t act);
    if (act !== exp) begin
      $display("FAIL %s row: expected %h got %h", name, exp, act);
      val_errs++;
    end
  endtask

  task automatic run_case(input int c);
    int nres;
    int waited;
    model_lu(c);
    for (int r = 0; r < N; r++) begin
      @(posedge clk_i);
      #1;
      load_en_i   = 1'b1;
      load_addr_i = `LU_AW'(r);
      load_row_i  = case_mat[c][r];
    end
    @(posedge clk_i);
    #1;
    load_en_i = 1'b0;
    start_i   = 1'b1;
    nres      = 0;
    waited    = 0;
    while (nres < N - 1) begin
      @(posedge clk_i);
      #1;
      start_i        = 1'b0;
      load_en_i      = 1'b0;
      result_ready_i = 1'b0;
      if (result_valid_o) begin
        check_result(case_name[c], exp_res[nres], result_o);   // also while stalled
        if (waited >= case_stall[c]) begin
          result_ready_i = 1'b1;
          nres++;
          waited = 0;
        end else begin
          waited++;
        end
      end
      if (case_poke[c] && busy_o) begin
        rng         = xorshift(rng);
        load_en_i   = 1'b1;
        load_addr_i = rng[`LU_AW-1:0];
        load_row_i  = {N{rng}};
        start_i     = 1'b1;
      end
    end
    @(posedge clk_i);
    #1;
    result_ready_i = 1'b0;
    load_en_i      = 1'b0;
    start_i        = 1'b0;
    if (busy_o || result_valid_o) begin
      $display("%s: unit still busy after its last result was taken", case_name[c]);
      proto_errs++;
    end
    for (int r = 0; r < N; r++) begin
      rd_addr_i = `LU_AW'(r);
      @(posedge clk_i);
      #1;
      check_row(case_name[c], exp_rows[r], rd_row_o);
    end
  endtask

  initial begin
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    load_en_i      = 1'b0;
    load_addr_i    = '0;
    load_row_i     = '0;
    start_i        = 1'b0;
    result_ready_i = 1'b0;
    rd_addr_i      = '0;
    rng            = 32'h14cf6745;
    val_errs       = 0;
    proto_errs     = 0;
    build_table();
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    for (int c = 0; c < NCASES; c++) run_case(c);
    $display("errors: %0d value, %0d protocol", val_errs, proto_errs);
    if (val_errs + proto_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(CYCLES * 40);
    $display("timeout: no verdict after %0d clock cycles", CYCLES);
    $display("** FAIL **");
    $finish;
  end

endmodule

// File: compile.f
+incdir+src
src/lu_pkg.sv
src/complex_mul.sv
src/complex_recip.sv
src/lu_row_bank.sv
src/lu_engine.sv
src/lu_top.sv
sim/lu_props.sv
sim/lu_tb.sv

// File: run.sh
#!/bin/sh
# build and run the LU testbench with Verilator, verdict from sim.log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module lu_tb \
  -o lu_sim > build.log 2>&1 &&
./obj_dir/lu_sim > sim.log 2>&1 || { cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1 || exit 0
